/* verilog/video_pkg.sv */
// Shared types for the DVI output path.
// Pixels come in as a palette index with sync and enable levels, leave the
// lookup as 6-bit RGB and leave the encoders as three 10-bit TMDS symbols.
// Import with a wildcard in the module header of any file that needs them.
package video_pkg;

   // one colour channel, as the VIC-II palette stores it
   typedef logic [5:0] chan_t;

   typedef struct packed {
      chan_t red;
      chan_t green;
      chan_t blue;
   } rgb_t;

   // pixel as delivered by the VIC-II core, one per clk_dvi
   typedef struct packed {
      logic       de;     // display enable, high in active video
      logic       hsync;
      logic       vsync;
      logic [3:0] idx;    // palette colour index
   } pixel_in_t;

   // looked-up pixel, feeds the three encoders
   typedef struct packed {
      logic de;
      logic hsync;
      logic vsync;
      rgb_t rgb;
   } pixel_rgb_t;

   typedef logic [9:0] tmds_sym_t;  // one parallel 10-bit symbol

   typedef struct packed {
      tmds_sym_t red;
      tmds_sym_t green;
      tmds_sym_t blue;
   } tmds_out_t;

endpackage

/* verilog/cfg_pkg.sv */
// Host configuration word layout and palette write types.
// One 23-bit word is either a palette entry write or a control write;
// the top bit says which. The loader decodes it through the union views.
package cfg_pkg;
   import video_pkg::*;

   localparam int PAL_IDX_W = 4;                // 16 VIC-II colours
   localparam int PAL_DEPTH = 1 << PAL_IDX_W;

   typedef logic [PAL_IDX_W-1:0] pal_idx_t;

   typedef enum logic {
      CFG_PAL = 1'b0,   // palette entry write
      CFG_CTL = 1'b1    // control write
   } cfg_kind_t;

   typedef struct packed {
      cfg_kind_t kind;
      pal_idx_t  idx;
      chan_t     red;
      chan_t     green;
      chan_t     blue;
   } cfg_pal_t;

   typedef struct packed {
      cfg_kind_t   kind;
      logic [20:0] rsvd;       // write as zero
      logic        dvi_enable;
   } cfg_ctl_t;

   // kind sits in the same bit for both views
   typedef union packed {
      cfg_pal_t pal;
      cfg_ctl_t ctl;
   } cfg_word_u;

   // pending write from loader to arbiter
   typedef struct packed {
      pal_idx_t idx;
      rgb_t     rgb;
   } pal_wr_t;

endpackage

/* verilog/palette_ram_arbiter.sv */
// Palette memory with a single port shared by the pixel lookup and the
// config loader. Reads win: a write is granted only in a cycle without a
// read, i.e. during blanking. Read data is registered at the read edge.
`timescale 1ns/1ps

module palette_ram_arbiter
   import video_pkg::*;
   import cfg_pkg::*;
(
   input  logic     clk_dvi,
   input  logic     arst_n,
   input  logic     rd_req,   // lookup wants an entry this cycle
   input  pal_idx_t rd_idx,
   output rgb_t     rd_rgb,   // valid the cycle after rd_req
   input  logic     wr_req,   // loader holds a pending write
   input  pal_wr_t  wr,
   output logic     wr_gnt    // write lands at this edge
);

   rgb_t     mem [PAL_DEPTH];  // 16 x 18 palette, contents not reset
   pal_idx_t port_addr;
   logic     port_we;

   // read priority, write only fills idle port cycles
   assign wr_gnt  = wr_req & ~rd_req;
   assign port_we = wr_gnt;

   // single address mux in front of the array
   assign port_addr = port_we ? wr.idx : rd_idx;

   always_ff @(posedge clk_dvi)
   begin
      if (port_we)
      begin
         mem[port_addr] <= wr.rgb;
      end
   end

   // output register, holds its value when the port is idle or writing
   always_ff @(posedge clk_dvi or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rd_rgb <= '0;   // black until the first read
      end
      else if (rd_req)
      begin
         rd_rgb <= mem[port_addr];
      end
   end

endmodule

/* verilog/palette_loader.sv */
// Config word decoder. Control words update the output enable at once;
// palette words are held as one pending write until the arbiter grants it.
// cfg_busy stays high while a write is pending, and the host must wait
// for it to fall, since strobes that arrive while busy are dropped.
`timescale 1ns/1ps

module palette_loader
   import video_pkg::*;
   import cfg_pkg::*;
(
   input  logic      clk_dvi,
   input  logic      arst_n,
   input  logic      cfg_strobe,  // one-cycle pulse from host
   input  cfg_word_u cfg_word,
   output logic      cfg_busy,
   output logic      dvi_enable,
   output logic      wr_req,
   output pal_wr_t   wr,
   input  logic      wr_gnt
);

   cfg_kind_t kind;
   logic      accept;
   logic      take_pal;
   logic      take_ctl;

   assign kind     = cfg_word.pal.kind;        // same bit in either view
   assign accept   = cfg_strobe & ~cfg_busy;   // busy strobes ignored
   assign take_pal = accept && (kind == CFG_PAL);
   assign take_ctl = accept && (kind == CFG_CTL);

   // busy doubles as the write request to the arbiter
   assign wr_req = cfg_busy;

   always_ff @(posedge clk_dvi or negedge arst_n)
   begin
      if (!arst_n)
      begin
         cfg_busy   <= 1'b0;
         dvi_enable <= 1'b0;
      end
      else
      begin
         if (take_ctl)
         begin
            dvi_enable <= cfg_word.ctl.dvi_enable;   // control never sets busy
         end
         if (take_pal)
         begin
            cfg_busy <= 1'b1;
         end
         else if (wr_gnt)
         begin
            cfg_busy <= 1'b0;   // write done at this edge
         end
      end
   end

   // pending entry, only loaded when not busy so it is stable until granted
   always_ff @(posedge clk_dvi)
   begin
      if (take_pal)
      begin
         wr.idx       <= cfg_word.pal.idx;
         wr.rgb.red   <= cfg_word.pal.red;
         wr.rgb.green <= cfg_word.pal.green;
         wr.rgb.blue  <= cfg_word.pal.blue;
      end
   end

endmodule

/* verilog/pixel_lookup.sv */
// Palette lookup stage. The incoming index addresses the memory directly;
// de, the syncs and the output enable are registered beside the memory's
// output register so everything lines up one cycle later.
// Blanking pixels and disabled output give black.
`timescale 1ns/1ps

module pixel_lookup
   import video_pkg::*;
   import cfg_pkg::*;
(
   input  logic       clk_dvi,
   input  logic       arst_n,
   input  pixel_in_t  pix,
   input  logic       dvi_enable,
   output logic       rd_req,
   output pal_idx_t   rd_idx,
   input  rgb_t       rd_rgb,    // registered by the arbiter
   output pixel_rgb_t pix_rgb
);

   logic de_q;      // de delayed to match rd_rgb
   logic hsync_q;
   logic vsync_q;
   logic en_q;      // enable sampled with the pixel
   logic show;

   // only active pixels use the port, blanking leaves it to the loader
   assign rd_req = pix.de;
   assign rd_idx = pix.idx;

   always_ff @(posedge clk_dvi or negedge arst_n)
   begin
      if (!arst_n)
      begin
         de_q    <= 1'b0;
         hsync_q <= 1'b0;
         vsync_q <= 1'b0;
         en_q    <= 1'b0;
      end
      else
      begin
         de_q    <= pix.de;
         hsync_q <= pix.hsync;
         vsync_q <= pix.vsync;
         en_q    <= dvi_enable;
      end
   end

   assign show = de_q & en_q;

   assign pix_rgb.de    = de_q;
   assign pix_rgb.hsync = hsync_q;   // syncs pass even when disabled
   assign pix_rgb.vsync = vsync_q;
   assign pix_rgb.rgb   = show ? rd_rgb : '0;

endmodule

/* verilog/tmds_encoder.sv */
// One DVI TMDS channel. The 6-bit channel is widened to 8 bits with two
// zero LSBs, then goes through the transition-minimising stage and the
// DC-balancing stage with a signed running disparity count.
// In blanking the symbol is one of the four control codes picked by c1/c0
// and the count is cleared. The symbol is registered.
`timescale 1ns/1ps

module tmds_encoder
   import video_pkg::*;
(
   input  logic      clk_dvi,
   input  logic      arst_n,
   input  logic      de,
   input  logic      c0,
   input  logic      c1,
   input  chan_t     data,
   output tmds_sym_t sym
);

   // control symbols, indexed by {c1, c0}
   localparam tmds_sym_t CTL_00 = 10'b1101010100;
   localparam tmds_sym_t CTL_01 = 10'b0010101011;
   localparam tmds_sym_t CTL_10 = 10'b0101010100;
   localparam tmds_sym_t CTL_11 = 10'b1010101011;

   logic [7:0]        d8;
   logic [3:0]        n1_d;       // ones in the input byte
   logic              use_xnor;
   logic [8:0]        q_m;        // stage one output, bit 8 = xor/xnor flag
   logic [3:0]        n1_q;
   logic [3:0]        n0_q;
   logic signed [4:0] bal;        // n1 - n0 of q_m[7:0]
   logic signed [4:0] cnt;        // running disparity
   logic signed [4:0] cnt_next;
   tmds_sym_t         sym_next;

   function automatic logic [3:0] ones8(input logic [7:0] v);
      logic [3:0] n;
      n = '0;
      for (int i = 0; i < 8; i++)
      begin
         n = n + 4'(v[i]);
      end
      return n;
   endfunction

   assign d8 = {data, 2'b00};   // 6-bit palette into the top of the byte

   assign n1_d     = ones8(d8);
   assign use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !d8[0]);

   // transition minimising chain
   always_comb
   begin
      q_m[0] = d8[0];
      for (int i = 1; i < 8; i++)
      begin
         q_m[i] = use_xnor ? ~(q_m[i-1] ^ d8[i]) : (q_m[i-1] ^ d8[i]);
      end
      q_m[8] = ~use_xnor;
   end

   assign n1_q = ones8(q_m[7:0]);
   assign n0_q = 4'd8 - n1_q;
   assign bal  = {1'b0, n1_q} - {1'b0, n0_q};   // wraps to the right signed value

   // DC balancing
   always_comb
   begin
      sym_next = CTL_00;
      cnt_next = '0;   // blanking clears the count
      if (de)
      begin
         if ((cnt == 0) || (bal == 0))
         begin
            sym_next = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            cnt_next = q_m[8] ? (cnt + bal) : (cnt - bal);
         end
         else if (((cnt > 0) && (bal > 0)) || ((cnt < 0) && (bal < 0)))
         begin
            sym_next = {1'b1, q_m[8], ~q_m[7:0]};   // invert to pull back
            cnt_next = cnt + (q_m[8] ? 5'sd2 : 5'sd0) - bal;
         end
         else
         begin
            sym_next = {1'b0, q_m[8], q_m[7:0]};
            cnt_next = cnt - (q_m[8] ? 5'sd0 : 5'sd2) + bal;
         end
      end
      else
      begin
         case ({c1, c0})
            2'b00:   sym_next = CTL_00;
            2'b01:   sym_next = CTL_01;
            2'b10:   sym_next = CTL_10;
            default: sym_next = CTL_11;
         endcase
      end
   end

   always_ff @(posedge clk_dvi or negedge arst_n)
   begin
      if (!arst_n)
      begin
         sym <= CTL_00;   // c1 = c0 = 0 out of reset
         cnt <= '0;
      end
      else
      begin
         sym <= sym_next;
         cnt <= cnt_next;
      end
   end

endmodule

/* verilog/dvi_out.sv */
// Top of the DVI output path in the clk_dvi domain.
// Pixel in at edge k, memory read at edge k, TMDS symbols out at edge k+1.
// Config words from the host go to the loader; the loader and the lookup
// share the palette port through the arbiter. Serializer is outside.
`timescale 1ns/1ps

module dvi_out
   import video_pkg::*;
   import cfg_pkg::*;
(
   input  logic      clk_dvi,
   input  logic      arst_n,
   input  pixel_in_t pix,
   input  logic      cfg_strobe,
   input  cfg_word_u cfg_word,
   output logic      cfg_busy,
   output tmds_out_t tmds
);

   logic       dvi_enable;
   logic       wr_req;
   logic       wr_gnt;
   pal_wr_t    wr;
   logic       rd_req;
   pal_idx_t   rd_idx;
   rgb_t       rd_rgb;
   pixel_rgb_t pix_rgb;

   palette_loader loader0 (
      .clk_dvi    (clk_dvi),
      .arst_n     (arst_n),
      .cfg_strobe (cfg_strobe),
      .cfg_word   (cfg_word),
      .cfg_busy   (cfg_busy),
      .dvi_enable (dvi_enable),
      .wr_req     (wr_req),
      .wr         (wr),
      .wr_gnt     (wr_gnt)
   );

   pixel_lookup lookup0 (
      .clk_dvi    (clk_dvi),
      .arst_n     (arst_n),
      .pix        (pix),
      .dvi_enable (dvi_enable),
      .rd_req     (rd_req),
      .rd_idx     (rd_idx),
      .rd_rgb     (rd_rgb),
      .pix_rgb    (pix_rgb)
   );

   palette_ram_arbiter arb0 (
      .clk_dvi (clk_dvi),
      .arst_n  (arst_n),
      .rd_req  (rd_req),
      .rd_idx  (rd_idx),
      .rd_rgb  (rd_rgb),
      .wr_req  (wr_req),
      .wr      (wr),
      .wr_gnt  (wr_gnt)
   );

   // red and green carry no control info in DVI
   tmds_encoder enc_r (
      .clk_dvi (clk_dvi),
      .arst_n  (arst_n),
      .de      (pix_rgb.de),
      .c0      (1'b0),
      .c1      (1'b0),
      .data    (pix_rgb.rgb.red),
      .sym     (tmds.red)
   );

   tmds_encoder enc_g (
      .clk_dvi (clk_dvi),
      .arst_n  (arst_n),
      .de      (pix_rgb.de),
      .c0      (1'b0),
      .c1      (1'b0),
      .data    (pix_rgb.rgb.green),
      .sym     (tmds.green)
   );

   tmds_encoder enc_b (
      .clk_dvi (clk_dvi),
      .arst_n  (arst_n),
      .de      (pix_rgb.de),
      .c0      (pix_rgb.hsync),   // syncs ride on the blue lane
      .c1      (pix_rgb.vsync),
      .data    (pix_rgb.rgb.blue),
      .sym     (tmds.blue)
   );

endmodule

/* dv/dvi_tb_model.svh */
// Reference model for the DVI output testbench, included in the tb module.
// Shadows the palette, the output enable and one pending palette write, and
// encodes expected TMDS symbols from the DVI 1.0 rules.
// Call model_step once per driven cycle, with the pixel and config inputs.
`ifndef DVI_TB_MODEL_SVH
`define DVI_TB_MODEL_SVH

rgb_t       shadow_pal [16];   // what the palette should hold
logic       shadow_en;
logic       exp_busy;          // palette write accepted, not granted yet
pal_wr_t    pend;
pixel_rgb_t lk_q;              // lookup stage, one cycle behind the pixel
tmds_out_t  exp_tmds;          // encoder stage, what tmds shows now
int         disp [3];          // running disparity, lanes red green blue

function automatic int ones_in(logic [7:0] b);
   int n;
   n = 0;
   for (int i = 0; i < 8; i++)
   begin
      n = n + int'(b[i]);
   end
   return n;
endfunction

// blanking codes from the DVI spec, c = {c1, c0}
function automatic tmds_sym_t ctrl_sym(logic [1:0] c);
   tmds_sym_t s;
   case (c)
      2'b00:   s = 10'h354;
      2'b01:   s = 10'h0ab;
      2'b10:   s = 10'h154;
      default: s = 10'h2ab;
   endcase
   return s;
endfunction

function automatic tmds_sym_t encode_ref(int lane, logic de, logic c1, logic c0, chan_t data);
   logic [7:0] d;
   logic [8:0] qm;
   int         n1d;
   int         n1;
   int         n0;
   tmds_sym_t  s;
   d     = {data, 2'b00};   // board widens 6 to 8 bits
   n1d   = ones_in(d);
   qm[0] = d[0];
   qm[8] = !((n1d > 4) || ((n1d == 4) && !d[0]));   // 1 means xor chain
   for (int i = 1; i < 8; i++)
   begin
      qm[i] = qm[i-1] ^ d[i] ^ ~qm[8];   // xnor when qm[8] is low
   end
   n1 = ones_in(qm[7:0]);
   n0 = 8 - n1;
   if (!de)
   begin
      s          = ctrl_sym({c1, c0});
      disp[lane] = 0;
   end
   else if ((disp[lane] == 0) || (n1 == n0))
   begin
      s          = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
      disp[lane] += qm[8] ? (n1 - n0) : (n0 - n1);
   end
   else if (((disp[lane] > 0) && (n1 > n0)) || ((disp[lane] < 0) && (n0 > n1)))
   begin
      s          = {1'b1, qm[8], ~qm[7:0]};   // inverted to pull back to zero
      disp[lane] += (qm[8] ? 2 : 0) + n0 - n1;
   end
   else
   begin
      s          = {1'b0, qm[8], qm[7:0]};
      disp[lane] += n1 - n0 - (qm[8] ? 0 : 2);
   end
   return s;
endfunction

task automatic model_reset();
   shadow_en = 1'b0;
   exp_busy  = 1'b0;
   pend      = '0;
   lk_q      = '0;
   exp_tmds  = {ctrl_sym(2'b00), ctrl_sym(2'b00), ctrl_sym(2'b00)};
   for (int i = 0; i < 3; i++)
   begin
      disp[i] = 0;
   end
   for (int i = 0; i < 16; i++)
   begin
      shadow_pal[i] = '0;   // DUT palette has no reset, vectors load it first
   end
endtask

// effect of the next rising edge, in pipeline order
task automatic model_step(pixel_in_t p, logic strobe, cfg_word_u w);
   exp_tmds.red   = encode_ref(0, lk_q.de, 1'b0, 1'b0, lk_q.rgb.red);
   exp_tmds.green = encode_ref(1, lk_q.de, 1'b0, 1'b0, lk_q.rgb.green);
   exp_tmds.blue  = encode_ref(2, lk_q.de, lk_q.vsync, lk_q.hsync, lk_q.rgb.blue);
   lk_q.de    = p.de;
   lk_q.hsync = p.hsync;
   lk_q.vsync = p.vsync;
   lk_q.rgb   = (p.de && shadow_en) ? shadow_pal[p.idx] : '0;   // old enable, old palette
   if (exp_busy && !p.de)
   begin
      shadow_pal[pend.idx] = pend.rgb;   // write lands in a blanking cycle
      exp_busy             = 1'b0;
   end
   else if (strobe && !exp_busy)
   begin
      if (w.pal.kind == CFG_PAL)
      begin
         pend.idx       = w.pal.idx;
         pend.rgb.red   = w.pal.red;
         pend.rgb.green = w.pal.green;
         pend.rgb.blue  = w.pal.blue;
         exp_busy       = 1'b1;
      end
      else
      begin
         shadow_en = w.ctl.dvi_enable;
      end
   end
endtask

`endif

/* dv/dvi_tb.sv */
// Testbench for the DVI output path.
// Reads operations from dv/dvi_vectors.txt, drives pixels and config words
// on the falling edge and checks the TMDS symbols and cfg_busy against the
// reference model on every falling edge. Run from the project root.
`timescale 1ns/1ps

module dvi_tb
   import video_pkg::*;
   import cfg_pkg::*;
();

   localparam int          REC_WORDS   = 7;     // op count de hsync vsync idx word
   localparam int          MAX_RECORDS = 64;
   localparam int          MARGIN      = 200;   // slack over the vector length
   localparam logic [31:0] OP_PIX      = 32'h0;
   localparam logic [31:0] OP_CFG      = 32'h1;
   localparam logic [31:0] OP_END      = 32'hf;
   localparam logic [31:0] IDX_RANDOM  = 32'h10;

   logic      clk_dvi;
   logic      arst_n;
   pixel_in_t pix;
   logic      cfg_strobe;
   cfg_word_u cfg_word;
   logic      cfg_busy;
   tmds_out_t tmds;

   logic [31:0] vec_mem [REC_WORDS*MAX_RECORDS];
   int          num_records;
   int          cycle_limit = 0;   // zero until the vectors are read
   int          cycle_count = 0;
   logic [31:0] rng_state;

   `include "dvi_tb_model.svh"

   dvi_out dut0 (
      .clk_dvi    (clk_dvi),
      .arst_n     (arst_n),
      .pix        (pix),
      .cfg_strobe (cfg_strobe),
      .cfg_word   (cfg_word),
      .cfg_busy   (cfg_busy),
      .tmds       (tmds)
   );

   initial
   begin
      clk_dvi = 1'b0;
      forever
      begin
         #20 clk_dvi = ~clk_dvi;   // 40 ns period
      end
   end

   task automatic stop_run();
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   always @(posedge clk_dvi)
   begin
      cycle_count = cycle_count + 1;
      if ((cycle_limit > 0) && (cycle_count > cycle_limit))
      begin
         $display("timeout, the vectors did not finish within %0d cycles", cycle_limit);
         stop_run();
      end
   end

   function automatic logic [31:0] xorshift32(logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check_tmds(tmds_out_t got, tmds_out_t exp);
      if (got !== exp)
      begin
         $display("Fail tmds got r=%h g=%h b=%h expected r=%h g=%h b=%h at %0t",
                  got.red, got.green, got.blue, exp.red, exp.green, exp.blue, $time);
         stop_run();
      end
   endtask

   task automatic check_busy(logic got, logic exp);
      if (got !== exp)
      begin
         $display("Fail cfg_busy got %h expected %h at %0t", got, exp, $time);
         stop_run();
      end
   endtask

   // scan records up to the end marker and size the timeout
   task automatic load_vectors();
      int          total;
      int          r;
      logic [31:0] op;
      total       = 0;
      r           = 0;
      num_records = -1;
      $readmemh("dv/dvi_vectors.txt", vec_mem);
      while ((num_records < 0) && (r < MAX_RECORDS))
      begin
         op = vec_mem[r * REC_WORDS];
         if (op == OP_END)
         begin
            num_records = r;
         end
         else if ((op != OP_PIX) && (op != OP_CFG))
         begin
            $display("vector record %0d has an unknown operation %h", r, op);
            stop_run();
         end
         else
         begin
            total = total + int'(vec_mem[r * REC_WORDS + 1]);
            r     = r + 1;
         end
      end
      if (num_records < 0)
      begin
         $display("the vector file has no end record");
         stop_run();
      end
      else
      begin
         cycle_limit = total + 4 + 2 + MARGIN;   // reset and flush too
      end
   endtask

   // called on a falling edge to check the last rising edge and drive the next one
   task automatic run_cycle(pixel_in_t p, logic strobe, cfg_word_u w);
      check_tmds(tmds, exp_tmds);
      check_busy(cfg_busy, exp_busy);
      pix        = p;
      cfg_strobe = strobe;
      cfg_word   = w;
      model_step(p, strobe, w);
      @(negedge clk_dvi);
   endtask

   initial
   begin
      int          base;
      int          run_len;
      logic        is_cfg;
      logic [31:0] idx_field;
      pixel_in_t   p;
      cfg_word_u   w;

      arst_n     = 1'b0;
      pix        = '0;
      cfg_strobe = 1'b0;
      cfg_word   = '0;
      rng_state  = 32'h37b6;
      load_vectors();
      model_reset();
      repeat (4) @(posedge clk_dvi);
      @(negedge clk_dvi);
      arst_n = 1'b1;
      for (int r = 0; r < num_records; r++)
      begin
         base      = r * REC_WORDS;
         is_cfg    = (vec_mem[base] == OP_CFG);   // strobe on the first cycle only
         run_len   = int'(vec_mem[base + 1]);
         idx_field = vec_mem[base + 5];
         w         = vec_mem[base + 6][22:0];
         for (int c = 0; c < run_len; c++)
         begin
            p.de    = vec_mem[base + 2][0];
            p.hsync = vec_mem[base + 3][0];
            p.vsync = vec_mem[base + 4][0];
            if (idx_field == IDX_RANDOM)
            begin
               rng_state = xorshift32(rng_state);
               p.idx     = rng_state[3:0];
            end
            else
            begin
               p.idx = idx_field[3:0];
            end
            run_cycle(p, is_cfg && (c == 0), w);
         end
      end
      check_tmds(tmds, exp_tmds);   // edge after the last driven cycle
      check_busy(cfg_busy, exp_busy);
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

/* dv/dvi_vectors.txt */
// columns: op count de hsync vsync idx word, all hex; op 0 pixel run, 1 config then run, f end
// idx 10 picks a random index each pixel; word is the 23-bit config word, strobed on cycle one
0 4 0 0 0 0 0             // idle after reset
0 3 0 1 0 0 0             // hsync only
0 3 0 0 1 0 0             // vsync only
0 3 0 1 1 0 0             // both syncs
1 2 0 0 0 0 000000        // palette load in blanking, one gap cycle each
1 2 0 0 0 0 07ffff
1 2 0 0 0 0 09a34a
1 2 0 0 0 0 0dcbf2
1 2 0 0 0 0 11b3e2
1 2 0 0 0 0 157991
1 2 0 0 0 0 18c2e5
1 2 0 0 0 0 1f3dde
1 2 0 0 0 0 21b50a
1 2 0 0 0 0 250380
1 2 0 0 0 0 2a6656
1 2 0 0 0 0 2d1451
1 2 0 0 0 0 31e79e
1 2 0 0 0 0 366d61
1 2 0 0 0 0 39b6b1
1 2 0 0 0 0 3eaaaa
1 1 0 0 0 0 400001        // output enable on
0 c0 1 0 0 10 0           // long random active lines
0 8 0 1 0 0 0
0 c0 1 0 0 10 0
0 4 0 1 1 0 0
1 1 0 0 0 0 400000        // output enable off
0 20 1 0 0 10 0           // black while disabled
0 4 0 0 1 0 0
0 20 1 1 0 10 0
1 1 0 0 0 0 400001        // enable again
0 10 1 0 0 3 0            // entry 3 before the update
1 4 1 0 0 3 0c0fc0        // write during active video, waits for blanking
1 4 1 0 0 3 0fffff        // strobe while busy, dropped
0 2 0 1 0 0 0             // write lands here
0 10 1 0 0 3 0            // entry 3 after the update
0 40 1 0 0 10 0
0 4 0 0 0 0 0             // flush
f 0 0 0 0 0 0

/* flist.f */
+incdir+dv
verilog/video_pkg.sv
verilog/cfg_pkg.sv
verilog/palette_ram_arbiter.sv
verilog/palette_loader.sv
verilog/pixel_lookup.sv
verilog/tmds_encoder.sv
verilog/dvi_out.sv
dv/dvi_tb.sv

/* Makefile */
# Verilator build and run of the DVI output testbench.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := dvi_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

SOURCES := $(wildcard verilog/*.sv dv/*.sv dv/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
